/* bench/vdec_ref.svh */
/*
  reference model for the vector decode stage
  byte-wise shadow of the register file and the expected contents
  of one registered pair, worked out from the instruction fields
*/
`ifndef VDEC_REF_SVH
`define VDEC_REF_SVH

typedef struct packed {
  logic [5:0]  aluop;
  vreg_sel_t   vd;
  offset_t     woff0;
  offset_t     woff1;
  logic        wen0;
  logic        wen1;
  lane_t       vs1_0;
  lane_t       vs1_1;
  lane_t       vs2_0;
  lane_t       vs2_1;
  logic [31:0] imm;
  sew_t        eew;
  logic        last;
} pair_exp_t;

// little-endian bytes of every vector register
logic [7:0] shadow_bytes [NUM_VREGS][VLENB];

function automatic void shadow_store(input vreg_sel_t r, input logic [1:0] w,
                                     input logic [31:0] data);
  int b;
  for (b = 0; b < 4; b++) begin
    shadow_bytes[r][4 * w + b] = data[8 * b +: 8];
  end
endfunction

function automatic int sew_bytes(input sew_t s);
  if (s == SEW8) begin
    return 1;
  end
  if (s == SEW16) begin
    return 2;
  end
  return 4;
endfunction

// element idx of register r, nbytes wide, zero past the register end
function automatic logic [31:0] shadow_elem(input vreg_sel_t r, input offset_t idx,
                                            input int nbytes);
  logic [31:0] val;
  int          b;
  val = '0;
  if (idx < VLENB / nbytes) begin
    for (b = 0; b < nbytes; b++) begin
      val[8 * b +: 8] = shadow_bytes[r][idx * nbytes + b];
    end
  end
  return val;
endfunction

function automatic logic mask_bit(input offset_t idx);
  if (idx < VLEN) begin
    return shadow_bytes[0][idx / 8][idx % 8];
  end
  return 1'b0;
endfunction

// vs2 lane after the slide1 scalar insert and narrowing truncation
function automatic logic [31:0] vs2_elem(input vreg_sel_t r, input offset_t idx,
                                         input int nb, input int nb2, input logic s1up,
                                         input logic s1dn, input offset_t start,
                                         input offset_t len, input logic [31:0] xval);
  logic [31:0] val;
  val = shadow_elem(r, idx, nb2);
  if (nb2 != nb) begin
    val = val & ((32'd1 << (8 * nb)) - 32'd1);
  end
  if (s1up && idx + 32'd1 == start) begin
    val = xval;
  end
  if (s1dn && idx == len) begin
    val = xval;
  end
  return val;
endfunction

function automatic pair_exp_t expected_pair(input logic [31:0] word, input offset_t len,
                                            input offset_t start, input sew_t sew,
                                            input logic [31:0] xval, input offset_t off);
  pair_exp_t   e;
  logic [5:0]  f6;
  logic [2:0]  f3;
  logic [4:0]  imm;
  logic        is_vx, is_vi, sup, sdn, s1up, s1dn, widen, narrow;
  logic [31:0] amt;
  offset_t     s2off0, s2off1;
  int          nb, nb2;
  e      = '0;
  f6     = word[31:26];
  f3     = word[14:12];
  imm    = word[19:15];
  is_vi  = (f3 == 3'b011);
  is_vx  = (f3 == 3'b100) || (f3 == 3'b110);
  sup    = (f6 == 6'b001110) && (is_vi || is_vx);
  sdn    = (f6 == 6'b001111) && (is_vi || is_vx);
  s1up   = sup && (f3 == 3'b110);
  s1dn   = sdn && (f3 == 3'b110);
  widen  = (f6[5:2] == 4'b1100);
  narrow = (f6[5:2] == 4'b1011);
  amt    = is_vi ? {27'd0, imm} : xval;
  nb     = sew_bytes(sew);
  nb2    = (narrow && nb < 4) ? 2 * nb : nb;

  e.aluop = f6;
  e.vd    = word[11:7];
  e.imm   = f6[5] ? {27'd0, imm} : {{27{imm[4]}}, imm};
  e.woff0 = off;
  e.woff1 = off + 32'd1;
  if (sup && !s1up) begin
    e.woff0 = off + amt;
    e.woff1 = off + amt + 32'd1;
  end

  s2off0 = off;
  s2off1 = off + 32'd1;
  if (sdn && !s1dn) begin
    s2off0 = off + amt;
    s2off1 = off + amt + 32'd1;
  end else if (s1up) begin
    s2off0 = off - 32'd1;
    s2off1 = off;
  end else if (s1dn) begin
    s2off0 = off + 32'd1;
    s2off1 = off + 32'd2;
  end

  if (is_vx) begin
    e.vs1_0 = xval;
    e.vs1_1 = xval;
  end else if (is_vi) begin
    e.vs1_0 = e.imm;
    e.vs1_1 = e.imm;
  end else begin
    e.vs1_0 = shadow_elem(word[19:15], off, nb);
    e.vs1_1 = shadow_elem(word[19:15], off + 32'd1, nb);
  end
  e.vs2_0 = vs2_elem(word[24:20], s2off0, nb, nb2, s1up, s1dn, start, len, xval);
  e.vs2_1 = vs2_elem(word[24:20], s2off1, nb, nb2, s1up, s1dn, start, len, xval);

  e.wen0 = (word[25] | mask_bit(e.woff0)) & (e.woff0 < len);
  e.wen1 = (word[25] | mask_bit(e.woff1)) & (e.woff1 < len);
  e.last = (off + 32'd2) >= len;

  e.eew = sew;
  if (widen) begin
    e.eew = (sew == SEW8) ? SEW16 : SEW32;
  end else if (narrow) begin
    e.eew = (sew == SEW32) ? SEW16 : SEW8;
  end
  return e;
endfunction

`endif

/* bench/vdecode_stage_tb.sv */
/*
  testbench for the vector decode stage
  fills the register file, walks instructions through every format,
  slide mode and width class, with stalls and a flush, and checks
  each registered pair against the reference model
*/
`timescale 1ns/100ps

module vdecode_stage_tb import vdec_pkg::*; ();

  localparam int NUM_INSTR   = 26;
  localparam int CLK_HALF    = 4;
  localparam int WATCHDOG_NS = (NUM_INSTR * (VLENB + 4) + 50) * 2 * CLK_HALF;

  logic        CLK, nRST;
  logic [31:0] instr;
  logic        instr_valid;
  offset_t     vl, vstart;
  sew_t        vsew;
  logic [31:0] xs1;
  logic        stall, flush;
  logic        wb_en;
  vreg_sel_t   wb_reg;
  logic [1:0]  wb_word;
  logic [31:0] wb_data;
  logic        busy, ex_valid, ex_wen0, ex_wen1, ex_last;
  logic [5:0]  ex_aluop;
  vreg_sel_t   ex_vd;
  offset_t     ex_woffset0, ex_woffset1;
  lane_t       ex_vs1_lane0, ex_vs1_lane1, ex_vs2_lane0, ex_vs2_lane1;
  logic [31:0] ex_imm;
  sew_t        ex_eew;

  int seed;
  int errors;

  `include "vdec_ref.svh"

  pair_exp_t expq[$];
  pair_exp_t want;

  vdecode_stage UUT (.*);

  always #CLK_HALF CLK = ~CLK;

  function automatic logic [31:0] make_opv(input logic [5:0] f6, input logic vm,
                                           input vreg_sel_t vs2, input logic [4:0] vs1,
                                           input logic [2:0] f3, input vreg_sel_t vd);
    return {f6, vm, vs2, vs1, f3, vd, OPCODE_OPV};
  endfunction

  function automatic logic pick_stall(input int pct);
    return ((($random(seed) & 32'h7fff_ffff) % 100) < pct);
  endfunction

  task automatic check_val(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic write_word(input vreg_sel_t r, input logic [1:0] w, input logic [31:0] data);
    @(posedge CLK);
    #1;
    wb_en   = 1'b1;
    wb_reg  = r;
    wb_word = w;
    wb_data = data;
    shadow_store(r, w, data);
  endtask

  task automatic fill_regs();
    int r;
    int w;
    for (r = 0; r < NUM_VREGS; r++) begin
      for (w = 0; w < WORDS_PER_VREG; w++) begin
        write_word(5'(r), 2'(w), $random(seed));
      end
    end
    @(posedge CLK);
    #1;
    wb_en = 1'b0;
  endtask

  task automatic present(input logic [31:0] word, input offset_t len, input offset_t start,
                         input sew_t sew, input logic [31:0] xval);
    instr       = word;
    vl          = len;
    vstart      = start;
    vsew        = sew;
    xs1         = xval;
    instr_valid = 1'b1;
  endtask

  // queue every expected pair, then hold the instruction until busy drops
  task automatic run_instr(input logic [31:0] word, input offset_t len, input offset_t start,
                           input sew_t sew, input logic [31:0] xval, input int stall_pct);
    offset_t off;
    int      npairs;
    int      issued;
    logic    done;
    off    = start;
    npairs = 0;
    done   = 1'b0;
    while (!done) begin
      expq.push_back(expected_pair(word, len, start, sew, xval, off));
      npairs++;
      if (off + 32'd2 >= len) begin
        done = 1'b1;
      end else begin
        off = off + 32'd2;
      end
    end
    @(posedge CLK);
    #1;
    present(word, len, start, sew, xval);
    stall  = pick_stall(stall_pct);
    issued = 0;
    done   = 1'b0;
    while (!done) begin
      @(negedge CLK);
      if (!stall) begin
        issued++;
      end
      if (!busy) begin
        done = 1'b1;
        if (issued != npairs) begin
          errors++;
          $display("CHECK FAILED at %0t: busy fell after %0d pairs, expected %0d",
                   $time, issued, npairs);
        end
      end else if (issued >= npairs) begin
        done = 1'b1;
        errors++;
        $display("CHECK FAILED at %0t: busy still high after %0d pairs", $time, issued);
      end
      @(posedge CLK);
      #1;
      stall = done ? 1'b0 : pick_stall(stall_pct);
    end
    instr_valid = 1'b0;
  endtask

  // issue a few pairs, then flush with the instruction still offered
  task automatic flush_walk(input logic [31:0] word, input offset_t len, input offset_t start,
                            input sew_t sew, input logic [31:0] xval, input int kept);
    int i;
    for (i = 0; i < kept; i++) begin
      expq.push_back(expected_pair(word, len, start, sew, xval, start + 32'(2 * i)));
    end
    @(posedge CLK);
    #1;
    present(word, len, start, sew, xval);
    stall = 1'b0;
    repeat (kept) @(posedge CLK);
    #1;
    flush = 1'b1;
    @(posedge CLK);
    #1;
    flush       = 1'b0;
    instr_valid = 1'b0;
    @(negedge CLK);
    if (ex_valid) begin
      errors++;
      $display("CHECK FAILED at %0t: ex_valid high after flush", $time);
    end
  endtask

  // compare each registered pair mid-cycle
  always @(negedge CLK) begin
    if (nRST && ex_valid) begin
      if (expq.size() == 0) begin
        errors++;
        $display("unexpected pair on the execute outputs at %0t", $time);
      end else begin
        want = expq.pop_front();
        check_val("ex_aluop", 32'(ex_aluop), 32'(want.aluop));
        check_val("ex_vd", 32'(ex_vd), 32'(want.vd));
        check_val("ex_woffset0", ex_woffset0, want.woff0);
        check_val("ex_woffset1", ex_woffset1, want.woff1);
        check_val("ex_wen0", 32'(ex_wen0), 32'(want.wen0));
        check_val("ex_wen1", 32'(ex_wen1), 32'(want.wen1));
        check_val("ex_vs1_lane0", ex_vs1_lane0, want.vs1_0);
        check_val("ex_vs1_lane1", ex_vs1_lane1, want.vs1_1);
        check_val("ex_vs2_lane0", ex_vs2_lane0, want.vs2_0);
        check_val("ex_vs2_lane1", ex_vs2_lane1, want.vs2_1);
        check_val("ex_imm", ex_imm, want.imm);
        check_val("ex_eew", 32'(ex_eew), 32'(want.eew));
        check_val("ex_last", 32'(ex_last), 32'(want.last));
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the stage stopped making progress", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

  initial begin
    seed        = 34798;
    errors      = 0;
    CLK         = 1'b0;
    nRST        = 1'b0;
    instr       = '0;
    instr_valid = 1'b0;
    vl          = '0;
    vstart      = '0;
    vsew        = SEW8;
    xs1         = '0;
    stall       = 1'b0;
    flush       = 1'b0;
    wb_en       = 1'b0;
    wb_reg      = '0;
    wb_word     = '0;
    wb_data     = '0;
    repeat (3) @(posedge CLK);
    #1;
    nRST = 1'b1;
    @(negedge CLK);
    if (ex_valid || ex_wen0 || ex_wen1 || ex_last || busy) begin
      errors++;
      $display("CHECK FAILED at %0t: outputs not idle after reset", $time);
    end
    fill_regs();

    // plain vector-vector walks at each width
    run_instr(make_opv(6'b000000, 1'b1, 5'd2, 5'd3, 3'b000, 5'd4), 16, 0, SEW8, 0, 0);
    run_instr(make_opv(6'b000000, 1'b1, 5'd5, 5'd6, 3'b000, 5'd7), 8, 0, SEW16, 0, 0);
    run_instr(make_opv(6'b000000, 1'b1, 5'd8, 5'd9, 3'b010, 5'd1), 4, 0, SEW32, 0, 0);
    // masked, odd tail, and vl below vstart
    run_instr(make_opv(6'b000000, 1'b0, 5'd2, 5'd3, 3'b000, 5'd4), 13, 0, SEW8, 0, 0);
    run_instr(make_opv(6'b000000, 1'b0, 5'd10, 5'd11, 3'b000, 5'd4), 7, 3, SEW16, 0, 0);
    run_instr(make_opv(6'b000000, 1'b1, 5'd2, 5'd3, 3'b000, 5'd4), 3, 5, SEW8, 0, 0);
    // scalar operand, signed and unsigned immediates
    run_instr(make_opv(6'b000000, 1'b1, 5'd12, 5'd0, 3'b100, 5'd4), 8, 0, SEW16,
              $random(seed), 0);
    run_instr(make_opv(6'b000000, 1'b1, 5'd12, 5'b10110, 3'b011, 5'd4), 16, 0, SEW8, 0, 0);
    run_instr(make_opv(6'b100101, 1'b1, 5'd12, 5'b10110, 3'b011, 5'd4), 4, 0, SEW32, 0, 0);
    // slides by scalar and immediate, then slide1
    run_instr(make_opv(6'b001110, 1'b1, 5'd13, 5'd0, 3'b100, 5'd5), 16, 0, SEW8, 3, 0);
    run_instr(make_opv(6'b001110, 1'b0, 5'd13, 5'd2, 3'b011, 5'd5), 8, 0, SEW16, 0, 0);
    run_instr(make_opv(6'b001111, 1'b1, 5'd14, 5'd0, 3'b100, 5'd5), 8, 0, SEW16, 5, 0);
    run_instr(make_opv(6'b001111, 1'b1, 5'd14, 5'd1, 3'b011, 5'd5), 4, 0, SEW32, 0, 0);
    run_instr(make_opv(6'b001110, 1'b1, 5'd15, 5'd0, 3'b110, 5'd6), 4, 0, SEW32,
              $random(seed), 0);
    run_instr(make_opv(6'b001111, 1'b1, 5'd15, 5'd0, 3'b110, 5'd6), 7, 0, SEW16,
              $random(seed), 0);
    // widening then narrowing
    run_instr(make_opv(6'b110000, 1'b1, 5'd16, 5'd17, 3'b010, 5'd8), 16, 0, SEW8, 0, 0);
    run_instr(make_opv(6'b110000, 1'b1, 5'd16, 5'd17, 3'b010, 5'd8), 8, 0, SEW16, 0, 0);
    run_instr(make_opv(6'b110001, 1'b1, 5'd16, 5'd17, 3'b010, 5'd8), 4, 0, SEW32, 0, 0);
    run_instr(make_opv(6'b101100, 1'b1, 5'd18, 5'd19, 3'b000, 5'd9), 8, 0, SEW8, 0, 0);
    run_instr(make_opv(6'b101100, 1'b1, 5'd18, 5'd19, 3'b000, 5'd9), 4, 0, SEW16, 0, 0);
    run_instr(make_opv(6'b101101, 1'b1, 5'd18, 5'd0, 3'b100, 5'd9), 4, 0, SEW32,
              $random(seed), 0);
    // random back-pressure
    run_instr(make_opv(6'b000000, 1'b0, 5'd20, 5'd21, 3'b000, 5'd3), 16, 0, SEW8, 0, 30);
    run_instr(make_opv(6'b001110, 1'b1, 5'd20, 5'd0, 3'b100, 5'd3), 8, 1, SEW16, 2, 30);
    run_instr(make_opv(6'b101100, 1'b1, 5'd22, 5'd23, 3'b000, 5'd3), 8, 0, SEW16, 0, 30);
    // flush part way, then the same instruction from vstart again
    flush_walk(make_opv(6'b000000, 1'b1, 5'd24, 5'd25, 3'b000, 5'd2), 16, 2, SEW8, 0, 3);
    run_instr(make_opv(6'b000000, 1'b1, 5'd24, 5'd25, 3'b000, 5'd2), 16, 2, SEW8, 0, 20);

    repeat (4) @(posedge CLK);
    if (expq.size() != 0) begin
      errors++;
      $display("%0d expected pairs never reached the execute outputs", expq.size());
    end
    $display("%0d errors", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module vdecode_stage_tb \
  -f vdecode.f -o vdecode_sim &&
./obj_dir/vdecode_sim | tee /dev/stderr | grep -qx "test passed" &&
exit 0 || exit 1

/* source/decode_execute_reg.sv */
/*
  decode to execute register
  picks the operand lanes, forms the lane write enables and the result
  element width, and registers one pair per step
*/
`timescale 1ns/100ps

module decode_execute_reg import vdec_pkg::*; (
  input logic           CLK,
  input logic           nRST,
  input logic           flush,
  input sew_t           vsew,
  input offset_t        vl,
  input offset_t        vstart,
  input logic [31:0]    xs1,
  vdec_ctrl_if.consumer dx_if,
  input lane_t          vs1_data0,
  input lane_t          vs1_data1,
  input lane_t          vs2_data0,
  input lane_t          vs2_data1,
  input logic           mask0,
  input logic           mask1,
  output logic          ex_valid,
  output logic [5:0]    ex_aluop,
  output vreg_sel_t     ex_vd,
  output offset_t       ex_woffset0,
  output offset_t       ex_woffset1,
  output logic          ex_wen0,
  output logic          ex_wen1,
  output lane_t         ex_vs1_lane0,
  output lane_t         ex_vs1_lane1,
  output lane_t         ex_vs2_lane0,
  output lane_t         ex_vs2_lane1,
  output logic [31:0]   ex_imm,
  output sew_t          ex_eew,
  output logic          ex_last
);

  logic [31:0] imm_ext;
  lane_t       vs1_lane0, vs1_lane1;
  lane_t       vs2_lane0, vs2_lane1;
  logic        wen0, wen1;
  sew_t        eew;

  function automatic lane_t pick_vs2(lane_t data, offset_t off, vctrl_t c, offset_t vs,
                                     offset_t len, lane_t x, sew_t sew);
    lane_t val;
    val = data;
    // slide1up lane sitting at vstart, slide1down lane at the tail
    if (c.addr_mode == ADDR_SLIDE1UP && off + 32'd1 == vs) begin
      val = x;
    end else if (c.addr_mode == ADDR_SLIDE1DOWN && off == len) begin
      val = x;
    end else if (c.width_mode == WIDTH_NARROW) begin
      case (sew)
        SEW8:    val = {24'd0, data[7:0]};
        SEW16:   val = {16'd0, data[15:0]};
        default: val = data;
      endcase
    end
    return val;
  endfunction

  // unsigned immediate when the funct6 top bit is set
  assign imm_ext = dx_if.ctrl.aluop[5] ? {27'd0, dx_if.ctrl.imm5}
                                       : {{27{dx_if.ctrl.imm5[4]}}, dx_if.ctrl.imm5};

  always_comb begin
    case (dx_if.ctrl.opsrc)
      SRC_VX: begin
        vs1_lane0 = xs1;
        vs1_lane1 = xs1;
      end
      SRC_VI: begin
        vs1_lane0 = imm_ext;
        vs1_lane1 = imm_ext;
      end
      default: begin
        vs1_lane0 = vs1_data0;
        vs1_lane1 = vs1_data1;
      end
    endcase
  end

  assign vs2_lane0 = pick_vs2(vs2_data0, dx_if.vs2_off0, dx_if.ctrl, vstart, vl, xs1, vsew);
  assign vs2_lane1 = pick_vs2(vs2_data1, dx_if.vs2_off1, dx_if.ctrl, vstart, vl, xs1, vsew);

  assign wen0 = (dx_if.ctrl.vm | mask0) & (dx_if.vd_off0 < vl);
  assign wen1 = (dx_if.ctrl.vm | mask1) & (dx_if.vd_off1 < vl);

  always_comb begin
    eew = vsew;
    if (dx_if.ctrl.width_mode == WIDTH_WIDEN) begin
      eew = (vsew == SEW8) ? SEW16 : SEW32;
    end else if (dx_if.ctrl.width_mode == WIDTH_NARROW) begin
      eew = (vsew == SEW32) ? SEW16 : SEW8;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_valid <= 1'b0;
      ex_wen0  <= 1'b0;
      ex_wen1  <= 1'b0;
      ex_last  <= 1'b0;
    end else if (flush) begin
      ex_valid <= 1'b0;
      ex_wen0  <= 1'b0;
      ex_wen1  <= 1'b0;
      ex_last  <= 1'b0;
    end else begin
      ex_valid <= dx_if.step;
      ex_wen0  <= dx_if.step & wen0;
      ex_wen1  <= dx_if.step & wen1;
      ex_last  <= dx_if.step & dx_if.last;
    end
  end

  // data fields only move with a pair
  always_ff @(posedge CLK) begin
    if (dx_if.step && !flush) begin
      ex_aluop     <= dx_if.ctrl.aluop;
      ex_vd        <= dx_if.ctrl.vd;
      ex_woffset0  <= dx_if.vd_off0;
      ex_woffset1  <= dx_if.vd_off1;
      ex_vs1_lane0 <= vs1_lane0;
      ex_vs1_lane1 <= vs1_lane1;
      ex_vs2_lane0 <= vs2_lane0;
      ex_vs2_lane1 <= vs2_lane1;
      ex_imm       <= imm_ext;
      ex_eew       <= eew;
    end
  end

  // vl and vstart stay put for the whole walk
  assert property (@(posedge CLK) disable iff (!nRST)
    dx_if.step && !dx_if.last && !flush |=> $stable(vl) && $stable(vstart))
    else $error("vl or vstart changed part way through a walk");

endmodule

/* source/element_addr_gen.sv */
/*
  element address generator
  turns the pair base index into vs1, vs2 and vd element offsets
  for both lanes under plain and slide addressing
*/
`timescale 1ns/100ps

module element_addr_gen import vdec_pkg::*; (
  input logic [31:0]   xs1,
  vdec_ctrl_if.addrgen ag_if
);

  offset_t amount;
  offset_t base;
  offset_t base_p1;
  offset_t shifted;

  // slide distance from uimm5 or the scalar operand
  assign amount  = (ag_if.ctrl.opsrc == SRC_VI) ? {27'd0, ag_if.ctrl.imm5} : xs1;
  assign base    = ag_if.offset;
  assign base_p1 = ag_if.offset + 32'd1;
  assign shifted = ag_if.offset + amount;

  assign ag_if.vs1_off0 = base;
  assign ag_if.vs1_off1 = base_p1;

  always_comb begin
    ag_if.vd_off0  = base;
    ag_if.vd_off1  = base_p1;
    ag_if.vs2_off0 = base;
    ag_if.vs2_off1 = base_p1;
    case (ag_if.ctrl.addr_mode)
      ADDR_SLIDEUP: begin
        ag_if.vd_off0 = shifted;
        ag_if.vd_off1 = shifted + 32'd1;
      end
      ADDR_SLIDEDOWN: begin
        ag_if.vs2_off0 = shifted;
        ag_if.vs2_off1 = shifted + 32'd1;
      end
      ADDR_SLIDE1UP: begin
        // wraps below zero at the first element, caught downstream
        ag_if.vs2_off0 = base - 32'd1;
        ag_if.vs2_off1 = base;
      end
      ADDR_SLIDE1DOWN: begin
        ag_if.vs2_off0 = base_p1;
        ag_if.vs2_off1 = base + 32'd2;
      end
      default: begin
      end
    endcase
  end

endmodule

/* source/element_counter.sv */
/*
  element counter
  walks the element index two at a time from vstart up to vl,
  flags the last pair and tells upstream when to hold the instruction
*/
`timescale 1ns/100ps

module element_counter import vdec_pkg::*; (
  input logic          CLK,
  input logic          nRST,
  input logic          instr_valid,
  input logic          stall,
  input logic          flush,
  input offset_t       vl,
  input offset_t       vstart,
  vdec_ctrl_if.counter cnt_if,
  output logic         busy
);

  // active is set while an instruction is part way through its walk
  logic    active;
  offset_t next_base;
  offset_t pair_end;

  assign cnt_if.offset = active ? next_base : vstart;
  assign pair_end      = cnt_if.offset + 32'd2;
  assign cnt_if.last   = pair_end >= vl;
  assign cnt_if.step   = instr_valid & cnt_if.ctrl.legal & ~stall;

  // a stalled last pair still has to be held upstream
  assign busy = instr_valid & cnt_if.ctrl.legal & (stall | ~cnt_if.last);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      active    <= 1'b0;
      next_base <= '0;
    end else if (flush) begin
      active <= 1'b0;
    end else if (cnt_if.step) begin
      active    <= ~cnt_if.last;
      next_base <= pair_end;
    end
  end

  // upstream keeps the instruction offered until its last pair issues
  assert property (@(posedge CLK) disable iff (!nRST)
    busy && !flush |=> instr_valid)
    else $error("instruction dropped while the walk was still busy");

endmodule

/* source/vdec_ctrl_if.sv */
/*
  decode stage control bundle
  decoded control, element counter state and the per-lane element
  offsets shared by the decoder, counter, address generator and readers
*/
`timescale 1ns/100ps

interface vdec_ctrl_if import vdec_pkg::*; ();

  vctrl_t  ctrl;
  offset_t offset;
  logic    last;
  logic    step;
  offset_t vs1_off0, vs1_off1;
  offset_t vs2_off0, vs2_off1;
  offset_t vd_off0, vd_off1;

  modport decoder (output ctrl);
  modport counter (input ctrl, output offset, last, step);
  modport addrgen (input ctrl, offset,
                   output vs1_off0, vs1_off1, vs2_off0, vs2_off1, vd_off0, vd_off1);
  modport consumer (input ctrl, offset, last, step,
                    vs1_off0, vs1_off1, vs2_off0, vs2_off1, vd_off0, vd_off1);

endinterface

/* source/vdec_pkg.sv */
/*
  vector decode package
  shared sizes, operand and addressing encodings, and the decoded
  control word passed between the decode stage blocks
*/
package vdec_pkg;

  localparam int VLEN           = 128;
  localparam int VLENB          = 16;
  localparam int NUM_VREGS      = 32;
  localparam int WORDS_PER_VREG = 4;

  // OP-V major opcode and the funct3 formats accepted
  localparam logic [6:0] OPCODE_OPV = 7'b1010111;
  localparam logic [2:0] F3_OPIVV   = 3'b000;
  localparam logic [2:0] F3_OPMVV   = 3'b010;
  localparam logic [2:0] F3_OPIVI   = 3'b011;
  localparam logic [2:0] F3_OPIVX   = 3'b100;
  localparam logic [2:0] F3_OPMVX   = 3'b110;

  localparam logic [5:0] F6_SLIDEUP   = 6'b001110;
  localparam logic [5:0] F6_SLIDEDOWN = 6'b001111;

  typedef logic [31:0] offset_t;
  typedef logic [4:0]  vreg_sel_t;
  typedef logic [31:0] lane_t;

  typedef enum logic [1:0] {SEW8 = 2'b00, SEW16 = 2'b01, SEW32 = 2'b10} sew_t;

  typedef enum logic [2:0] {
    ADDR_NORMAL, ADDR_SLIDEUP, ADDR_SLIDEDOWN, ADDR_SLIDE1UP, ADDR_SLIDE1DOWN
  } addr_mode_t;

  typedef enum logic [1:0] {SRC_VV, SRC_VX, SRC_VI} opsrc_t;

  typedef enum logic [1:0] {WIDTH_SAME, WIDTH_WIDEN, WIDTH_NARROW} width_mode_t;

  typedef struct packed {
    logic [5:0]  aluop;
    vreg_sel_t   vs1;
    vreg_sel_t   vs2;
    vreg_sel_t   vd;
    logic [4:0]  imm5;
    logic        vm;      // set means unmasked
    addr_mode_t  addr_mode;
    opsrc_t      opsrc;
    width_mode_t width_mode;
    logic        legal;
  } vctrl_t;

endpackage

/* source/vdecode_stage.sv */
/*
  vector decode stage
  decoder, element counter, offset generator and register file feeding
  the decode to execute register of a two-lane vector unit
*/
`timescale 1ns/100ps

module vdecode_stage import vdec_pkg::*; (
  input logic         CLK,
  input logic         nRST,
  input logic [31:0]  instr,
  input logic         instr_valid,
  input offset_t      vl,
  input offset_t      vstart,
  input sew_t         vsew,
  input logic [31:0]  xs1,
  input logic         stall,
  input logic         flush,
  input logic         wb_en,
  input vreg_sel_t    wb_reg,
  input logic [1:0]   wb_word,
  input logic [31:0]  wb_data,
  output logic        busy,
  output logic        ex_valid,
  output logic [5:0]  ex_aluop,
  output vreg_sel_t   ex_vd,
  output offset_t     ex_woffset0,
  output offset_t     ex_woffset1,
  output logic        ex_wen0,
  output logic        ex_wen1,
  output lane_t       ex_vs1_lane0,
  output lane_t       ex_vs1_lane1,
  output lane_t       ex_vs2_lane0,
  output lane_t       ex_vs2_lane1,
  output logic [31:0] ex_imm,
  output sew_t        ex_eew,
  output logic        ex_last
);

  lane_t vs1_data0, vs1_data1;
  lane_t vs2_data0, vs2_data1;
  logic  mask0, mask1;

  vdec_ctrl_if ctrl_if ();

  vinstr_decoder u_decoder (
    .instr  (instr),
    .dec_if (ctrl_if)
  );

  element_counter u_counter (
    .CLK         (CLK),
    .nRST        (nRST),
    .instr_valid (instr_valid),
    .stall       (stall),
    .flush       (flush),
    .vl          (vl),
    .vstart      (vstart),
    .cnt_if      (ctrl_if),
    .busy        (busy)
  );

  element_addr_gen u_addr_gen (
    .xs1   (xs1),
    .ag_if (ctrl_if)
  );

  vreg_file u_vreg_file (
    .CLK       (CLK),
    .nRST      (nRST),
    .wb_en     (wb_en),
    .wb_reg    (wb_reg),
    .wb_word   (wb_word),
    .wb_data   (wb_data),
    .vsew      (vsew),
    .rf_if     (ctrl_if),
    .vs1_data0 (vs1_data0),
    .vs1_data1 (vs1_data1),
    .vs2_data0 (vs2_data0),
    .vs2_data1 (vs2_data1),
    .mask0     (mask0),
    .mask1     (mask1)
  );

  decode_execute_reg u_dx_reg (
    .CLK          (CLK),
    .nRST         (nRST),
    .flush        (flush),
    .vsew         (vsew),
    .vl           (vl),
    .vstart       (vstart),
    .xs1          (xs1),
    .dx_if        (ctrl_if),
    .vs1_data0    (vs1_data0),
    .vs1_data1    (vs1_data1),
    .vs2_data0    (vs2_data0),
    .vs2_data1    (vs2_data1),
    .mask0        (mask0),
    .mask1        (mask1),
    .ex_valid     (ex_valid),
    .ex_aluop     (ex_aluop),
    .ex_vd        (ex_vd),
    .ex_woffset0  (ex_woffset0),
    .ex_woffset1  (ex_woffset1),
    .ex_wen0      (ex_wen0),
    .ex_wen1      (ex_wen1),
    .ex_vs1_lane0 (ex_vs1_lane0),
    .ex_vs1_lane1 (ex_vs1_lane1),
    .ex_vs2_lane0 (ex_vs2_lane0),
    .ex_vs2_lane1 (ex_vs2_lane1),
    .ex_imm       (ex_imm),
    .ex_eew       (ex_eew),
    .ex_last      (ex_last)
  );

endmodule

/* source/vinstr_decoder.sv */
/*
  vector instruction decoder
  splits an OP-V arithmetic word into register fields and picks the
  operand format, addressing mode and result width class
*/
`timescale 1ns/100ps

module vinstr_decoder import vdec_pkg::*; (
  input logic [31:0]   instr,
  vdec_ctrl_if.decoder dec_if
);

  vctrl_t     ctrl;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [5:0] funct6;
  logic       fmt_ok;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct6 = instr[31:26];

  always_comb begin
    ctrl       = '0;
    fmt_ok     = 1'b1;
    ctrl.aluop = funct6;
    ctrl.vs1   = instr[19:15];
    ctrl.vs2   = instr[24:20];
    ctrl.vd    = instr[11:7];
    ctrl.imm5  = instr[19:15];
    ctrl.vm    = instr[25];

    case (funct3)
      F3_OPIVV, F3_OPMVV: ctrl.opsrc = SRC_VV;
      F3_OPIVX, F3_OPMVX: ctrl.opsrc = SRC_VX;
      F3_OPIVI:           ctrl.opsrc = SRC_VI;
      default: begin
        ctrl.opsrc = SRC_VV;
        fmt_ok     = 1'b0;
      end
    endcase
    ctrl.legal = (opcode == OPCODE_OPV) && fmt_ok;

    // slide1 forms live in the OPM scalar format
    ctrl.addr_mode = ADDR_NORMAL;
    if (funct6 == F6_SLIDEUP && ctrl.opsrc != SRC_VV) begin
      ctrl.addr_mode = (funct3 == F3_OPMVX) ? ADDR_SLIDE1UP : ADDR_SLIDEUP;
    end else if (funct6 == F6_SLIDEDOWN && ctrl.opsrc != SRC_VV) begin
      ctrl.addr_mode = (funct3 == F3_OPMVX) ? ADDR_SLIDE1DOWN : ADDR_SLIDEDOWN;
    end

    // 1100xx widening, 1011xx narrowing
    ctrl.width_mode = WIDTH_SAME;
    if (funct6[5:2] == 4'b1100) begin
      ctrl.width_mode = WIDTH_WIDEN;
    end else if (funct6[5:2] == 4'b1011) begin
      ctrl.width_mode = WIDTH_NARROW;
    end

    dec_if.ctrl = ctrl;
  end

endmodule

/* source/vreg_file.sv */
/*
  vector register file
  32 registers of VLEN bits, one 32-bit word written per cycle,
  two elements per source read at the element width, v0 mask bits out
*/
`timescale 1ns/100ps

module vreg_file import vdec_pkg::*; (
  input logic           CLK,
  input logic           nRST,
  input logic           wb_en,
  input vreg_sel_t      wb_reg,
  input logic [1:0]     wb_word,
  input logic [31:0]    wb_data,
  input sew_t           vsew,
  vdec_ctrl_if.consumer rf_if,
  output lane_t         vs1_data0,
  output lane_t         vs1_data1,
  output lane_t         vs2_data0,
  output lane_t         vs2_data1,
  output logic          mask0,
  output logic          mask1
);

  logic [WORDS_PER_VREG-1:0][31:0] regs [NUM_VREGS];
  logic [VLEN-1:0] vs1_vec;
  logic [VLEN-1:0] vs2_vec;
  logic [VLEN-1:0] v0_vec;
  sew_t            vs2_sew;

  // zero-extended element, 0 past the end of the register
  function automatic lane_t read_elem(logic [VLEN-1:0] vec, offset_t idx, sew_t sew);
    logic [VLEN-1:0] shifted;
    lane_t           val;
    shifted = vec >> (idx << (sew + 3));
    val     = '0;
    case (sew)
      SEW8:    if (idx < VLENB) val = {24'd0, shifted[7:0]};
      SEW16:   if (idx < VLENB / 2) val = {16'd0, shifted[15:0]};
      default: if (idx < VLENB / 4) val = shifted[31:0];
    endcase
    return val;
  endfunction

  always_ff @(posedge CLK) begin
    if (wb_en) begin
      regs[wb_reg][wb_word] <= wb_data;
    end
  end

  assign vs1_vec = regs[rf_if.ctrl.vs1];
  assign vs2_vec = regs[rf_if.ctrl.vs2];
  assign v0_vec  = regs[0];

  // narrowing sources are twice as wide
  always_comb begin
    vs2_sew = vsew;
    if (rf_if.ctrl.width_mode == WIDTH_NARROW) begin
      vs2_sew = (vsew == SEW8) ? SEW16 : SEW32;
    end
  end

  assign vs1_data0 = read_elem(vs1_vec, rf_if.vs1_off0, vsew);
  assign vs1_data1 = read_elem(vs1_vec, rf_if.vs1_off1, vsew);
  assign vs2_data0 = read_elem(vs2_vec, rf_if.vs2_off0, vs2_sew);
  assign vs2_data1 = read_elem(vs2_vec, rf_if.vs2_off1, vs2_sew);

  assign mask0 = (rf_if.vd_off0 < VLEN) && v0_vec[rf_if.vd_off0[$clog2(VLEN)-1:0]];
  assign mask1 = (rf_if.vd_off1 < VLEN) && v0_vec[rf_if.vd_off1[$clog2(VLEN)-1:0]];

  // element reads only at a defined width
  assert property (@(posedge CLK) disable iff (!nRST)
    rf_if.step |-> vsew inside {SEW8, SEW16, SEW32})
    else $error("reserved element width while reading a pair");

endmodule

/* vdecode.f */
+incdir+bench
source/vdec_pkg.sv
source/vdec_ctrl_if.sv
source/vinstr_decoder.sv
source/element_counter.sv
source/element_addr_gen.sv
source/vreg_file.sv
source/decode_execute_reg.sv
source/vdecode_stage.sv
bench/vdecode_stage_tb.sv
